// ==== hdl/soc_pkg.sv ====
package soc_pkg;

  // bus and datapath widths
  localparam int PC_W   = 10;  // program word address
  localparam int INSN_W = 16;  // instruction word
  localparam int DATA_W = 8;   // data byte, accumulator

  localparam int PROG_DEPTH = 1 << PC_W;    // program ram words
  localparam int DMEM_DEPTH = 1 << DATA_W;  // data ram bytes

  // uart bit time, kept short for simulation
  // a 27 MHz board at 115200 baud wants about 234
  localparam int CLKS_PER_BIT = 16;
  localparam int UART_CNT_W   = $clog2(CLKS_PER_BIT);

  // memory mapped registers at the bottom of data space
  localparam logic [DATA_W-1:0] MMIO_OUT_ADDR  = 8'd0;  // cpu_out port
  localparam logic [DATA_W-1:0] MMIO_TX_ADDR   = 8'd1;  // store starts uart tx
  localparam logic [DATA_W-1:0] MMIO_STAT_ADDR = 8'd2;  // bit 0 is tx busy

  // end of program marker, never written to ram
  localparam logic [INSN_W-1:0] PROG_END_WORD = 16'hffff;

endpackage

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

  // top nibble of every instruction
  typedef enum logic [3:0] {
    OP_ALU_IMM = 4'h1,  // acc = func(acc, imm)
    OP_ALU_MEM = 4'h2,  // acc = func(acc, mem[addr])
    OP_ST      = 4'h3,  // mem[addr] = acc, or mmio
    OP_BR      = 4'h4,  // pc = target when cond holds
    OP_HALT    = 4'h5   // stop fetching
  } opcode_e;           // other codes run as no-ops

  typedef enum logic [3:0] {
    F_PASS = 4'h0,  // acc takes operand
    F_ADD  = 4'h1,
    F_SUB  = 4'h2,
    F_AND  = 4'h3,
    F_OR   = 4'h4,
    F_XOR  = 4'h5
  } alu_func_e;

  // tested against the accumulator only, no carry
  typedef enum logic [1:0] {
    BR_ALWAYS  = 2'd0,
    BR_ZERO    = 2'd1,
    BR_NONZERO = 2'd2,
    BR_NEG     = 2'd3   // acc bit 7
  } br_cond_e;

  typedef struct packed {
    opcode_e    opcode;
    alu_func_e  func;
    logic [7:0] operand;  // immediate or data address
  } data_view_t;

  typedef struct packed {
    opcode_e    opcode;
    br_cond_e   cond;
    logic [9:0] target;   // full program address
  } br_view_t;

  // same word, decoded by opcode
  typedef union packed {
    data_view_t data_view;
    br_view_t   br_view;
  } insn_u;

endpackage

// ==== hdl/mem_bus_if.sv ====
`timescale 1ns/1ps

// one master's port into program ram
interface mem_bus_if import soc_pkg::*; ();

  logic              req;     // single cycle, or held until granted
  logic              we;      // loader writes only
  logic [PC_W-1:0]   addr;
  logic [INSN_W-1:0] wdata;
  logic [INSN_W-1:0] rdata;   // good while rvalid is high
  logic              rvalid;  // one cycle after an accepted read

  modport master (output req, we, addr, wdata, input rdata, rvalid);

  modport slave (input req, we, addr, wdata, output rdata, rvalid);

endinterface

// ==== hdl/uart.sv ====
`timescale 1ns/1ps

module uart import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              rx,
  output logic              tx,
  output logic [DATA_W-1:0] rx_data,
  output logic              rx_strobe,
  input  logic [DATA_W-1:0] tx_data,
  input  logic              tx_strobe,
  output logic              tx_busy
);

  logic [1:0]            rx_sync;    // [1] is the clean line
  logic                  rx_active;  // inside a frame
  logic [3:0]            rx_bit;     // 0 start, 1..8 data, 9 stop
  logic [UART_CNT_W-1:0] rx_cnt;     // clocks to next sample point
  logic [DATA_W-1:0]     rx_shift;   // lsb arrives first
  logic [9:0]            tx_frame;   // {stop, data, start}, bit 0 on the line
  logic [3:0]            tx_bit;
  logic [UART_CNT_W-1:0] tx_cnt;

  assign rx_data = rx_shift;  // holds from strobe until next data bit
  assign tx      = tx_frame[0];

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;  // idle line is high
    end else begin
      rx_sync <= {rx_sync[0], rx};
    end
  end

  // rx sequencer, samples every bit at its middle
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_active <= 1'b0;
      rx_bit    <= 4'd0;
      rx_cnt    <= '0;
      rx_strobe <= 1'b0;
    end else begin
      rx_strobe <= 1'b0;
      if (!rx_active) begin
        if (!rx_sync[1]) begin  // start bit edge
          rx_active <= 1'b1;
          rx_bit    <= 4'd0;
          rx_cnt    <= UART_CNT_W'(CLKS_PER_BIT / 2 - 1);  // half a bit
        end
      end else if (rx_cnt != '0) begin
        rx_cnt <= rx_cnt - UART_CNT_W'(1);
      end else begin
        rx_cnt <= UART_CNT_W'(CLKS_PER_BIT - 1);
        rx_bit <= rx_bit + 4'd1;
        if (rx_bit == 4'd0 && rx_sync[1]) begin
          rx_active <= 1'b0;  // glitch, line back high
        end else if (rx_bit == 4'd9) begin
          rx_active <= 1'b0;  // middle of stop bit, no framing check
          rx_strobe <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_active && rx_cnt == '0 && rx_bit != 4'd0 && rx_bit != 4'd9) begin
      rx_shift <= {rx_sync[1], rx_shift[DATA_W-1:1]};
    end
  end

  // tx, strobe is dropped while a frame is going out
  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      tx_frame <= '1;
      tx_busy  <= 1'b0;
      tx_bit   <= 4'd0;
      tx_cnt   <= '0;
    end else if (!tx_busy) begin
      if (tx_strobe) begin
        tx_frame <= {1'b1, tx_data, 1'b0};
        tx_busy  <= 1'b1;
        tx_bit   <= 4'd0;
        tx_cnt   <= UART_CNT_W'(CLKS_PER_BIT - 1);
      end
    end else if (tx_cnt != '0) begin
      tx_cnt <= tx_cnt - UART_CNT_W'(1);
    end else begin
      tx_cnt   <= UART_CNT_W'(CLKS_PER_BIT - 1);
      tx_frame <= {1'b1, tx_frame[9:1]};  // refill with idle ones
      tx_bit   <= tx_bit + 4'd1;
      if (tx_bit == 4'd9) begin
        tx_busy <= 1'b0;  // stop bit done, 10 bit times total
      end
    end
  end

endmodule

// ==== hdl/prog_loader.sv ====
`timescale 1ns/1ps

module prog_loader import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic [DATA_W-1:0] rx_data,
  input  logic              rx_strobe,
  mem_bus_if.master         bus,
  output logic              load_done
);

  logic              phase;      // 0 waits for high byte, 1 for low byte
  logic [INSN_W-1:0] word_q;     // two most recent bytes
  logic [INSN_W-1:0] word_next;
  logic [PC_W-1:0]   wr_addr;    // next free program word
  logic              pair_end;   // low byte arriving now

  assign word_next = {word_q[DATA_W-1:0], rx_data};
  assign pair_end  = rx_strobe && phase;

  assign bus.we    = bus.req;  // never reads
  assign bus.addr  = wr_addr;
  assign bus.wdata = word_q;

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      phase     <= 1'b0;
      bus.req   <= 1'b0;
      load_done <= 1'b0;
      wr_addr   <= '0;
    end else begin
      bus.req <= pair_end && word_next != PROG_END_WORD;  // one cycle after the strobe
      if (rx_strobe) begin
        phase     <= ~phase;
        load_done <= 1'b0;  // any byte starts a new load
      end
      if (pair_end && word_next == PROG_END_WORD) begin
        load_done <= 1'b1;  // terminator, nothing written
        wr_addr   <= '0;
      end else if (bus.req) begin
        wr_addr <= wr_addr + PC_W'(1);
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_strobe) begin
      word_q <= word_next;  // high byte shifts up
    end
  end

endmodule

// ==== hdl/prog_mem_arb.sv ====
`timescale 1ns/1ps

module prog_mem_arb import soc_pkg::*; (
  input logic      sys_clk,
  input logic      rst_n,
  mem_bus_if.slave load_port,
  mem_bus_if.slave fetch_port
);

  logic [INSN_W-1:0] ram [PROG_DEPTH];  // single port
  logic [INSN_W-1:0] rd_q;
  logic [PC_W-1:0]   port_addr;
  logic              wr_en;
  logic              fetch_acc;  // read granted this cycle

  // loader has priority and is never stalled
  assign fetch_acc = fetch_port.req && !load_port.req;
  assign wr_en     = load_port.req && load_port.we;
  assign port_addr = load_port.req ? load_port.addr : fetch_port.addr;

  always_ff @(posedge sys_clk) begin
    if (wr_en) begin
      ram[port_addr] <= load_port.wdata;
    end
    if (fetch_acc) begin
      rd_q <= ram[port_addr];
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_port.rvalid <= 1'b0;
    end else begin
      fetch_port.rvalid <= fetch_acc;  // exactly one cycle later
    end
  end

  assign fetch_port.rdata = rd_q;
  assign load_port.rdata  = rd_q;  // shared read register
  assign load_port.rvalid = 1'b0;  // loader only writes

endmodule

// ==== hdl/acc_cpu.sv ====
`timescale 1ns/1ps

module acc_cpu import soc_pkg::*, isa_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              load_done,
  mem_bus_if.master         fetch,
  output logic [DATA_W-1:0] tx_data,
  output logic              tx_strobe,
  input  logic              tx_busy,
  output logic [DATA_W-1:0] cpu_out,
  output logic              halted
);

  logic [DATA_W-1:0] dmem [DMEM_DEPTH];
  logic [DATA_W-1:0] dmem_q;      // read together with the fetch
  logic [DATA_W-1:0] mem_rd;      // operand after mmio decode
  logic [PC_W-1:0]   pc;
  logic [DATA_W-1:0] acc;
  logic              exec;        // 0 fetch, 1 execute
  insn_u             fetch_word;  // word on the bus
  insn_u             ir;
  logic              br_take;
  logic              st_en;

  function automatic logic [DATA_W-1:0] alu(input alu_func_e f,
                                            input logic [DATA_W-1:0] a,
                                            input logic [DATA_W-1:0] b);
    case (f)
      F_PASS:  alu = b;
      F_ADD:   alu = a + b;
      F_SUB:   alu = a - b;  // wraps, bit 7 gives BR_NEG
      F_AND:   alu = a & b;
      F_OR:    alu = a | b;
      F_XOR:   alu = a ^ b;
      default: alu = a;      // unused codes leave acc alone
    endcase
  endfunction

  assign fetch_word  = fetch.rdata;
  // held until the word comes back, drops on rvalid
  assign fetch.req   = load_done && !halted && !exec && !fetch.rvalid;
  assign fetch.we    = 1'b0;
  assign fetch.addr  = pc;
  assign fetch.wdata = '0;

  assign st_en  = exec && ir.data_view.opcode == OP_ST;
  assign mem_rd = (ir.data_view.operand == MMIO_STAT_ADDR) ?
                  {{(DATA_W-1){1'b0}}, tx_busy} : dmem_q;

  always_comb begin
    case (ir.br_view.cond)
      BR_ALWAYS:  br_take = 1'b1;
      BR_ZERO:    br_take = acc == '0;
      BR_NONZERO: br_take = acc != '0;
      BR_NEG:     br_take = acc[DATA_W-1];
      default:    br_take = 1'b0;
    endcase
  end

  // data ram, ir and tx byte
  always_ff @(posedge sys_clk) begin
    if (st_en) begin
      dmem[ir.data_view.operand] <= acc;  // mmio addresses land here too
    end
    if (st_en && ir.data_view.operand == MMIO_TX_ADDR) begin
      tx_data <= acc;
    end
    if (fetch.rvalid) begin
      ir     <= fetch_word;
      dmem_q <= dmem[fetch_word.data_view.operand];  // only ALU_MEM uses it
    end
  end

  always_ff @(posedge sys_clk or negedge rst_n) begin
    if (!rst_n) begin
      pc        <= '0;
      acc       <= '0;
      exec      <= 1'b0;
      halted    <= 1'b0;
      tx_strobe <= 1'b0;
      cpu_out   <= '0;
    end else begin
      tx_strobe <= 1'b0;
      if (!load_done) begin  // held while a program loads
        pc     <= '0;
        acc    <= '0;
        exec   <= 1'b0;
        halted <= 1'b0;
      end else if (!exec) begin
        exec <= fetch.rvalid;
      end else begin
        exec <= 1'b0;
        pc   <= pc + PC_W'(1);
        case (ir.data_view.opcode)
          OP_ALU_IMM: acc <= alu(ir.data_view.func, acc, ir.data_view.operand);
          OP_ALU_MEM: acc <= alu(ir.data_view.func, acc, mem_rd);
          OP_ST: begin
            if (ir.data_view.operand == MMIO_OUT_ADDR) begin
              cpu_out <= acc;
            end
            tx_strobe <= ir.data_view.operand == MMIO_TX_ADDR;  // uart drops it if busy
          end
          OP_BR: begin
            if (br_take) begin
              pc <= ir.br_view.target;
            end
          end
          OP_HALT: begin
            halted <= 1'b1;  // sticky until next load
            pc     <= pc;
          end
          default: ;  // no-op
        endcase
      end
    end
  end

endmodule

// ==== hdl/soc_top.sv ====
`timescale 1ns/1ps

module soc_top import soc_pkg::*; (
  input  logic              sys_clk,
  input  logic              rst_n,
  input  logic              uart_rx,
  output logic              uart_tx,
  output logic [DATA_W-1:0] cpu_out,
  output logic              running,
  output logic              halted
);

  logic [DATA_W-1:0] rx_data;
  logic              rx_strobe;
  logic [DATA_W-1:0] tx_data;
  logic              tx_strobe;
  logic              tx_busy;
  logic              load_done;  // program in ram, cpu may run

  mem_bus_if load_bus ();   // loader writes
  mem_bus_if fetch_bus ();  // cpu reads

  assign running = load_done;

  uart u_uart (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .rx        (uart_rx),
    .tx        (uart_tx),
    .rx_data   (rx_data),
    .rx_strobe (rx_strobe),
    .tx_data   (tx_data),
    .tx_strobe (tx_strobe),
    .tx_busy   (tx_busy)
  );

  prog_loader u_loader (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .rx_data   (rx_data),
    .rx_strobe (rx_strobe),
    .bus       (load_bus),
    .load_done (load_done)
  );

  prog_mem_arb u_arb (
    .sys_clk    (sys_clk),
    .rst_n      (rst_n),
    .load_port  (load_bus),
    .fetch_port (fetch_bus)
  );

  acc_cpu u_cpu (
    .sys_clk   (sys_clk),
    .rst_n     (rst_n),
    .load_done (load_done),
    .fetch     (fetch_bus),
    .tx_data   (tx_data),
    .tx_strobe (tx_strobe),
    .tx_busy   (tx_busy),
    .cpu_out   (cpu_out),
    .halted    (halted)
  );

endmodule

// ==== tests/soc_props.sv ====
`timescale 1ns/1ps

module arb_props (
  input logic sys_clk,
  input logic rst_n,
  input logic load_req,
  input logic load_we,
  input logic fetch_req,
  input logic rvalid
);

  int fail_count = 0;  // failures seen so far

  // loader cycles never hand data to the fetch port
  no_rvalid_after_load: assert property (@(posedge sys_clk) disable iff (!rst_n)
    load_req |=> !rvalid)
    else begin
      fail_count++;
      $error("fetch rvalid right after a load request");
    end

  // fetch request on a free ram cycle
  read_gives_rvalid: assert property (@(posedge sys_clk) disable iff (!rst_n)
    fetch_req && !load_req |=> rvalid)  // exactly one cycle later
    else begin
      fail_count++;
      $error("accepted read without rvalid one cycle later");
    end

  // single ram port, every rvalid comes from a read that met no write
  no_write_and_read: assert property (@(posedge sys_clk) disable iff (!rst_n)
    rvalid |-> $past(fetch_req && !(load_req && load_we)))
    else begin
      fail_count++;
      $error("write and read accepted in one cycle");
    end

endmodule

bind prog_mem_arb arb_props u_props (
  .sys_clk   (sys_clk),
  .rst_n     (rst_n),
  .load_req  (load_port.req),
  .load_we   (load_port.we),
  .fetch_req (fetch_port.req),
  .rvalid    (fetch_port.rvalid)
);

// ==== tests/soc_tb.sv ====
`timescale 1ns/1ps

module soc_tb import soc_pkg::*, isa_pkg::*; ();

  localparam int WAIT_LIMIT = 20000;  // cycles for one signal wait
  localparam int RECV_LIMIT = 40000;  // covers a whole program load
  localparam logic [DATA_W-1:0] TMP_ADDR = 8'h10;  // acc parked here while polling

  logic              sys_clk;
  logic              rst_n;
  logic              uart_rx;
  logic              uart_tx;
  logic [DATA_W-1:0] cpu_out;
  logic              running;
  logic              halted;

  insn_u             prog_q[$];  // program being built
  logic [DATA_W-1:0] exp_q[$];   // model tx bytes
  logic [DATA_W-1:0] got_q[$];   // bytes seen on uart_tx
  logic [DATA_W-1:0] exp_out;    // model cpu_out
  int                value_errors;
  int                other_errors;
  int                seed = 32'hb48d_ef46;

  soc_top UUT (
    .sys_clk (sys_clk),
    .rst_n   (rst_n),
    .uart_rx (uart_rx),
    .uart_tx (uart_tx),
    .cpu_out (cpu_out),
    .running (running),
    .halted  (halted)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;  // 100 MHz
  end

  task automatic check_byte(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %02h expected %02h", $time, name, got, exp);
      value_errors++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, got, exp);
      value_errors++;
    end
  endtask

  // assembler helpers
  function automatic insn_u data_op(opcode_e op, alu_func_e f, logic [DATA_W-1:0] operand);
    insn_u w;
    w.data_view.opcode  = op;
    w.data_view.func    = f;
    w.data_view.operand = operand;
    return w;
  endfunction

  function automatic insn_u br_op(br_cond_e c, int target);
    insn_u w;
    w.br_view.opcode = OP_BR;
    w.br_view.cond   = c;
    w.br_view.target = PC_W'(target);
    return w;
  endfunction

  // park acc, spin on busy, reload and send
  function automatic void emit_tx();
    int poll;
    prog_q.push_back(data_op(OP_ST, F_PASS, TMP_ADDR));
    poll = prog_q.size();
    prog_q.push_back(data_op(OP_ALU_MEM, F_PASS, MMIO_STAT_ADDR));
    prog_q.push_back(br_op(BR_NONZERO, poll));
    prog_q.push_back(data_op(OP_ALU_MEM, F_PASS, TMP_ADDR));
    prog_q.push_back(data_op(OP_ST, F_PASS, MMIO_TX_ADDR));
  endfunction

  function automatic void imm_then_tx(alu_func_e f, logic [DATA_W-1:0] v);
    prog_q.push_back(data_op(OP_ALU_IMM, f, v));
    emit_tx();
  endfunction

  function automatic logic [DATA_W-1:0] alu_model(alu_func_e f, logic [DATA_W-1:0] a,
                                                  logic [DATA_W-1:0] b);
    case (f)
      F_PASS:  return b;
      F_ADD:   return a + b;  // 8 bit wrap
      F_SUB:   return a - b;
      F_AND:   return a & b;
      F_OR:    return a | b;
      F_XOR:   return a ^ b;
      default: return a;
    endcase
  endfunction

  // runs prog_q per the isa, fills exp_q and exp_out
  function automatic void run_model();
    logic [DATA_W-1:0] acc;
    logic [DATA_W-1:0] mem [256];
    logic [DATA_W-1:0] opnd;
    logic              take;
    logic              done;
    insn_u             w;
    int                pc;
    int                steps;
    acc     = '0;
    pc      = 0;
    steps   = 0;
    done    = 1'b0;
    exp_out = '0;
    exp_q.delete();
    foreach (mem[i]) mem[i] = '0;
    while (!done && pc < prog_q.size() && steps < 5000) begin
      w = prog_q[pc];
      pc++;
      steps++;
      case (w.data_view.opcode)
        OP_ALU_IMM: acc = alu_model(w.data_view.func, acc, w.data_view.operand);
        OP_ALU_MEM: begin
          // model sees an idle uart
          opnd = (w.data_view.operand == MMIO_STAT_ADDR) ? '0 : mem[w.data_view.operand];
          acc  = alu_model(w.data_view.func, acc, opnd);
        end
        OP_ST: begin
          mem[w.data_view.operand] = acc;
          if (w.data_view.operand == MMIO_OUT_ADDR) exp_out = acc;
          if (w.data_view.operand == MMIO_TX_ADDR) exp_q.push_back(acc);
        end
        OP_BR: begin
          case (w.br_view.cond)
            BR_ALWAYS:  take = 1'b1;
            BR_ZERO:    take = (acc == 8'h00);
            BR_NONZERO: take = (acc != 8'h00);
            default:    take = acc[7];  // negative
          endcase
          if (take) pc = int'(w.br_view.target);
        end
        OP_HALT: done = 1'b1;
        default: ;  // no-op
      endcase
    end
  endfunction

  // uart driver, 8N1 lsb first
  task automatic send_byte(input logic [DATA_W-1:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(negedge sys_clk);
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT - 1) @(negedge sys_clk);
    end
  endtask

  task automatic send_word(input logic [INSN_W-1:0] w);
    send_byte(w[15:8]);  // high byte first
    send_byte(w[7:0]);
  endtask

  task automatic send_program();
    foreach (prog_q[i]) begin
      send_word(prog_q[i]);
    end
    send_word(PROG_END_WORD);
  endtask

  // uart monitor, samples each bit in its middle
  task automatic recv_byte(output logic [DATA_W-1:0] b, output bit ok);
    int n;
    n = 0;
    b = '0;
    while (uart_tx !== 1'b0 && n < RECV_LIMIT) begin
      @(negedge sys_clk);
      n++;
    end
    ok = (uart_tx === 1'b0);
    if (ok) begin
      repeat (CLKS_PER_BIT / 2) @(negedge sys_clk);  // mid start bit
      for (int i = 0; i < DATA_W; i++) begin
        repeat (CLKS_PER_BIT) @(negedge sys_clk);
        b[i] = uart_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge sys_clk);
      if (uart_tx !== 1'b1) begin
        $display("ERROR t=%0t: no stop bit on uart_tx", $time);
        other_errors++;
      end
    end
  endtask

  task automatic collect_bytes(input int count);
    logic [DATA_W-1:0] b;
    bit                ok;
    got_q.delete();
    ok = 1'b1;
    for (int i = 0; i < count && ok; i++) begin
      recv_byte(b, ok);
      if (ok) begin
        got_q.push_back(b);
      end else begin
        $display("ERROR t=%0t: uart_tx byte %0d never started", $time, i);
        other_errors++;
      end
    end
  endtask

  task automatic compare_stream(input string tag);
    if (got_q.size() != exp_q.size()) begin
      $display("ERROR t=%0t: %s got %0d bytes, expected %0d", $time, tag,
               got_q.size(), exp_q.size());
      other_errors++;
    end
    for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
      check_byte($sformatf("%s uart_tx byte %0d", tag, i), got_q[i], exp_q[i]);
    end
  endtask

  task automatic wait_running(input logic level);
    int n;
    n = 0;
    while (running !== level && n < WAIT_LIMIT) begin
      @(negedge sys_clk);
      n++;
    end
    if (running !== level) begin
      $display("ERROR t=%0t: running never went to %b", $time, level);
      other_errors++;
    end
  endtask

  task automatic wait_halted();
    int n;
    n = 0;
    while (halted !== 1'b1 && n < WAIT_LIMIT) begin
      @(negedge sys_clk);
      n++;
    end
    if (halted !== 1'b1) begin
      $display("ERROR t=%0t: cpu did not halt", $time);
      other_errors++;
    end
  endtask

  task automatic wait_out(input logic [DATA_W-1:0] value);
    int n;
    n = 0;
    while (cpu_out !== value && n < WAIT_LIMIT) begin
      @(negedge sys_clk);
      n++;
    end
    check_byte("cpu_out", cpu_out, value);
  endtask

  // model first, then load and listen at once
  task automatic load_and_run(input string tag);
    run_model();
    fork
      send_program();
      collect_bytes(exp_q.size());
    join
    compare_stream(tag);
    wait_halted();
  endtask

  task automatic test_reset();
    check_bit("uart_tx", uart_tx, 1'b1);
    check_bit("running", running, 1'b0);
    check_bit("halted", halted, 1'b0);
    check_byte("cpu_out", cpu_out, 8'h00);
  endtask

  task automatic test_load_output();
    prog_q.delete();
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'h5a));
    prog_q.push_back(data_op(OP_ST, F_PASS, MMIO_OUT_ADDR));
    prog_q.push_back(data_op(OP_HALT, F_PASS, 8'h00));
    send_program();
    wait_running(1'b1);
    wait_halted();
    check_byte("cpu_out", cpu_out, 8'h5a);
  endtask

  task automatic test_alu_tx();
    prog_q.delete();
    imm_then_tx(F_PASS, 8'h5c);
    imm_then_tx(F_ADD, 8'h27);
    imm_then_tx(F_SUB, 8'h90);  // borrows
    imm_then_tx(F_AND, 8'h3f);
    imm_then_tx(F_OR, 8'hc0);
    imm_then_tx(F_XOR, 8'ha5);
    prog_q.push_back(data_op(OP_ST, F_PASS, 8'h20));
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'h07));
    prog_q.push_back(data_op(OP_ALU_MEM, F_ADD, 8'h20));
    emit_tx();
    prog_q.push_back(data_op(OP_ST, F_PASS, 8'h21));
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'h0f));
    prog_q.push_back(data_op(OP_ALU_MEM, F_XOR, 8'h21));
    prog_q.push_back(data_op(OP_ALU_MEM, F_SUB, 8'h20));
    emit_tx();
    prog_q.push_back(data_op(OP_HALT, F_PASS, 8'h00));
    load_and_run("alu");
  endtask

  task automatic test_branches();
    int loop;
    prog_q.delete();
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'h03));
    loop = prog_q.size();
    emit_tx();  // 3, 2, 1
    prog_q.push_back(data_op(OP_ALU_IMM, F_SUB, 8'h01));
    prog_q.push_back(br_op(BR_NONZERO, loop));
    prog_q.push_back(br_op(BR_ALWAYS, prog_q.size() + 7));  // over the ee block
    imm_then_tx(F_PASS, 8'hee);
    prog_q.push_back(data_op(OP_ALU_IMM, F_SUB, 8'h02));  // 0 - 2 is negative
    prog_q.push_back(br_op(BR_NEG, prog_q.size() + 2));
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'hee));
    emit_tx();
    prog_q.push_back(data_op(OP_HALT, F_PASS, 8'h00));
    load_and_run("branch");
  endtask

  task automatic test_reload();
    logic [INSN_W-1:0] first;
    prog_q.delete();
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'h33));
    prog_q.push_back(data_op(OP_ST, F_PASS, MMIO_OUT_ADDR));
    prog_q.push_back(br_op(BR_ALWAYS, 2));  // spin forever
    send_program();
    wait_out(8'h33);
    check_bit("running", running, 1'b1);
    prog_q.delete();
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'hc3));
    prog_q.push_back(data_op(OP_ST, F_PASS, MMIO_OUT_ADDR));
    prog_q.push_back(data_op(OP_HALT, F_PASS, 8'h00));
    run_model();
    first = prog_q[0];
    send_byte(first[15:8]);
    check_bit("running", running, 1'b0);  // first byte stops the cpu
    send_byte(first[7:0]);
    for (int i = 1; i < prog_q.size(); i++) begin
      send_word(prog_q[i]);
    end
    send_word(PROG_END_WORD);
    wait_running(1'b1);
    wait_halted();
    check_byte("cpu_out", cpu_out, exp_out);
  endtask

  task automatic test_random();
    logic [DATA_W-1:0] imm;
    prog_q.delete();
    prog_q.push_back(data_op(OP_ALU_IMM, F_PASS, 8'h00));
    for (int i = 0; i < 8; i++) begin
      imm = 8'($random(seed));
      imm_then_tx((i % 2 == 0) ? F_ADD : F_XOR, imm);
    end
    prog_q.push_back(data_op(OP_HALT, F_PASS, 8'h00));
    load_and_run("random");
  endtask

  initial begin
    rst_n        = 1'b0;
    uart_rx      = 1'b1;  // idle line
    value_errors = 0;
    other_errors = 0;
    repeat (8) @(posedge sys_clk);
    @(negedge sys_clk);
    rst_n = 1'b1;
    @(negedge sys_clk);
    test_reset();
    test_load_output();
    test_alu_tx();
    test_branches();
    test_reload();
    test_random();
    $display("errors: value %0d, other %0d, assertion %0d", value_errors, other_errors,
             UUT.u_arb.u_props.fail_count);
    if (value_errors + other_errors + UUT.u_arb.u_props.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
hdl/soc_pkg.sv
hdl/isa_pkg.sv
hdl/mem_bus_if.sv
hdl/uart.sv
hdl/prog_loader.sv
hdl/prog_mem_arb.sv
hdl/acc_cpu.sv
hdl/soc_top.sv
tests/soc_props.sv
tests/soc_tb.sv

// ==== Makefile ====
SIM       = verilator
TOP       = soc_tb
FILELIST  = sources.f
SIM_FLAGS = --binary --timing --assert -j 0
RUN_FLAGS = +verilator+error+limit+100
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(BUILD_DIR)
